// File: bench/clock_gen.sv
// testbench clock and reset
`timescale 1ns/10ps

module clock_gen #(
    parameter int HALF_PERIOD  = 50,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // reset released just after the last reset edge
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
    end

endmodule

// File: bench/udp_loopback_assert.sv
// tx channel handshake assertions
`timescale 1ns/10ps

module udp_loopback_assert (
    input logic                   clk,
    input logic                   rst,
    input logic                   tx_hdr_valid,
    input logic                   tx_hdr_ready,
    input udp_pkg::ip_addr_t      tx_hdr_dest_ip,
    input udp_pkg::udp_port_t     tx_hdr_src_port,
    input udp_pkg::udp_port_t     tx_hdr_dest_port,
    input udp_pkg::udp_len_t      tx_hdr_length,
    input udp_pkg::payload_data_t tx_payload_data,
    input udp_pkg::payload_keep_t tx_payload_keep,
    input logic                   tx_payload_valid,
    input logic                   tx_payload_ready,
    input logic                   tx_payload_last,
    input logic                   tx_payload_user
);

    // reply header frozen while stalled
    hdr_stable: assert property (
        @(posedge clk) disable iff (rst)
        (tx_hdr_valid && !tx_hdr_ready) |=>
            (tx_hdr_valid && $stable(tx_hdr_dest_ip) && $stable(tx_hdr_src_port) &&
             $stable(tx_hdr_dest_port) && $stable(tx_hdr_length))
    ) else $error("reply header changed while stalled");

    // payload beat frozen while stalled
    payload_stable: assert property (
        @(posedge clk) disable iff (rst)
        (tx_payload_valid && !tx_payload_ready) |=>
            (tx_payload_valid && $stable(tx_payload_data) && $stable(tx_payload_keep) &&
             $stable(tx_payload_last) && $stable(tx_payload_user))
    ) else $error("payload beat changed while stalled");

    // every beat carries at least one byte
    keep_nonzero: assert property (
        @(posedge clk) disable iff (rst)
        (tx_payload_valid && tx_payload_ready) |-> (tx_payload_keep != '0)
    ) else $error("payload beat transferred with empty keep");

endmodule

// File: bench/udp_loopback_tb.sv
// udp loopback testbench
`timescale 1ns/10ps

module udp_loopback_tb;
    import udp_pkg::*;

    localparam udp_port_t LOOPBACK_PORT   = 16'd1234;
    localparam int        FIFO_ADDR_WIDTH = 4;
    localparam int        NUM_ROWS        = 8;

    // one frame of stimulus
    typedef struct {
        udp_port_t dest_port;
        udp_port_t src_port;
        ip_addr_t  src_ip;
        udp_len_t  length;
        int        beats;
        logic      bp;
    } row_t;

    logic          clk;
    logic          rst;
    logic          rx_hdr_valid;
    logic          rx_hdr_ready;
    ip_addr_t      rx_hdr_src_ip;
    udp_port_t     rx_hdr_src_port;
    udp_port_t     rx_hdr_dest_port;
    udp_len_t      rx_hdr_length;
    payload_data_t rx_payload_data;
    payload_keep_t rx_payload_keep;
    logic          rx_payload_valid;
    logic          rx_payload_ready;
    logic          rx_payload_last;
    logic          rx_payload_user;
    logic          tx_hdr_valid;
    logic          tx_hdr_ready;
    ip_addr_t      tx_hdr_dest_ip;
    udp_port_t     tx_hdr_src_port;
    udp_port_t     tx_hdr_dest_port;
    udp_len_t      tx_hdr_length;
    payload_data_t tx_payload_data;
    payload_keep_t tx_payload_keep;
    logic          tx_payload_valid;
    logic          tx_payload_ready;
    logic          tx_payload_last;
    logic          tx_payload_user;
    led_byte_t     led;

    row_t rows [NUM_ROWS];

    // scoreboard, reply headers and payload beats in order
    ip_addr_t      exp_ip_q[$];
    udp_port_t     exp_sport_q[$];
    udp_port_t     exp_dport_q[$];
    udp_len_t      exp_len_q[$];
    payload_data_t exp_data_q[$];
    payload_keep_t exp_keep_q[$];
    logic          exp_last_q[$];
    logic          exp_user_q[$];

    logic [31:0] lfsr;
    logic        bp_on;
    logic        rst_seen;
    logic        hdr_fired;
    logic        pay_fired;
    logic        out_first;
    logic        led_pending;
    led_byte_t   led_expect;
    int          cycles;
    int          cycle_limit;
    int          n_checks;
    int          n_mismatch;
    int          n_other;

    clock_gen clock0 (
        .clk(clk),
        .rst(rst)
    );

    udp_loopback_top #(
        .LOOPBACK_PORT(LOOPBACK_PORT),
        .FIFO_ADDR_WIDTH(FIFO_ADDR_WIDTH)
    ) dut0 (.*);

    bind udp_loopback_top udp_loopback_assert assert0 (
        .clk(clk),
        .rst(rst),
        .tx_hdr_valid(tx_hdr_valid),
        .tx_hdr_ready(tx_hdr_ready),
        .tx_hdr_dest_ip(tx_hdr_dest_ip),
        .tx_hdr_src_port(tx_hdr_src_port),
        .tx_hdr_dest_port(tx_hdr_dest_port),
        .tx_hdr_length(tx_hdr_length),
        .tx_payload_data(tx_payload_data),
        .tx_payload_keep(tx_payload_keep),
        .tx_payload_valid(tx_payload_valid),
        .tx_payload_ready(tx_payload_ready),
        .tx_payload_last(tx_payload_last),
        .tx_payload_user(tx_payload_user)
    );

    // x^32 + x^22 + x^2 + x + 1, shifts toward the msb
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic draw_bit();
        lfsr = lfsr_step(lfsr);
        return lfsr[0];
    endfunction

    function automatic payload_data_t draw_data();
        payload_data_t v;
        v = '0;
        for (int i = 0; i < DATA_W; i++) begin
            v = {v[DATA_W-2:0], draw_bit()};
        end
        return v;
    endfunction

    // byte enables of the closing beat, from the udp length
    function automatic payload_keep_t last_keep(input udp_len_t length);
        int rem;
        rem = (int'(length) - 8) % 8;
        if (rem == 0) begin
            return 8'hff;
        end
        return payload_keep_t'(8'hff >> (8 - rem));
    endfunction

    task automatic check_ip(input string name, input ip_addr_t exp, input ip_addr_t act);
        n_checks++;
        if (act !== exp) begin
            n_mismatch++;
            $display("Mismatch at %0t ns: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_port(input string name, input udp_port_t exp, input udp_port_t act);
        n_checks++;
        if (act !== exp) begin
            n_mismatch++;
            $display("Mismatch at %0t ns: %s expected %0d, got %0d", $time, name, exp, act);
        end
    endtask

    task automatic check_len(input string name, input udp_len_t exp, input udp_len_t act);
        n_checks++;
        if (act !== exp) begin
            n_mismatch++;
            $display("Mismatch at %0t ns: %s expected %0d, got %0d", $time, name, exp, act);
        end
    endtask

    task automatic check_data(input string name, input payload_data_t exp,
                              input payload_data_t act);
        n_checks++;
        if (act !== exp) begin
            n_mismatch++;
            $display("Mismatch at %0t ns: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_keep(input string name, input payload_keep_t exp,
                              input payload_keep_t act);
        n_checks++;
        if (act !== exp) begin
            n_mismatch++;
            $display("Mismatch at %0t ns: %s expected %b, got %b", $time, name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        n_checks++;
        if (act !== exp) begin
            n_mismatch++;
            $display("Mismatch at %0t ns: %s expected %b, got %b", $time, name, exp, act);
        end
    endtask

    task automatic check_led(input string name, input led_byte_t exp, input led_byte_t act);
        n_checks++;
        if (act !== exp) begin
            n_mismatch++;
            $display("Mismatch at %0t ns: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic print_counts();
        $display("checks %0d, mismatches %0d, other errors %0d", n_checks, n_mismatch, n_other);
    endtask

    // output monitor, called at the falling edge ahead of each transfer
    task automatic watch_outputs();
        if (led_pending) begin
            check_led("led", led_expect, led);
            led_pending = 1'b0;
        end
        if (tx_hdr_valid && tx_hdr_ready) begin
            if (exp_ip_q.size() == 0) begin
                n_other++;
                $display("unexpected reply header at %0t ns", $time);
            end else begin
                check_ip("tx_hdr_dest_ip", exp_ip_q.pop_front(), tx_hdr_dest_ip);
                check_port("tx_hdr_src_port", exp_sport_q.pop_front(), tx_hdr_src_port);
                check_port("tx_hdr_dest_port", exp_dport_q.pop_front(), tx_hdr_dest_port);
                check_len("tx_hdr_length", exp_len_q.pop_front(), tx_hdr_length);
            end
        end
        if (tx_payload_valid && tx_payload_ready) begin
            if (exp_data_q.size() == 0) begin
                n_other++;
                $display("unexpected payload beat at %0t ns", $time);
            end else begin
                // led follows the opening beat of each outgoing frame
                if (out_first) begin
                    led_pending = 1'b1;
                    led_expect  = exp_data_q[0][7:0];
                end
                out_first = exp_last_q[0];
                check_data("tx_payload_data", exp_data_q.pop_front(), tx_payload_data);
                check_keep("tx_payload_keep", exp_keep_q.pop_front(), tx_payload_keep);
                check_bit("tx_payload_last", exp_last_q.pop_front(), tx_payload_last);
                check_bit("tx_payload_user", exp_user_q.pop_front(), tx_payload_user);
            end
        end
    endtask

    task automatic drive_ready();
        if (bp_on) begin
            tx_hdr_ready     = draw_bit();
            tx_payload_ready = draw_bit();
        end else begin
            tx_hdr_ready     = 1'b1;
            tx_payload_ready = 1'b1;
        end
    endtask

    // one clock, sample at the falling edge, drive 1 ns after the rising edge
    task automatic next_cycle();
        @(negedge clk);
        rst_seen  = rst;
        hdr_fired = rx_hdr_valid && rx_hdr_ready;
        pay_fired = rx_payload_valid && rx_payload_ready;
        if (!rst) begin
            watch_outputs();
        end
        @(posedge clk);
        #1;
        drive_ready();
    endtask

    // dest port, src port, src ip, udp length, beats, back-pressure
    task automatic load_table();
        rows[0] = '{16'd1234, 16'd5000, 32'hc0a8_0101, 16'd40, 4, 1'b0};
        rows[1] = '{16'd80, 16'd5001, 32'hc0a8_0102, 16'd28, 3, 1'b0};
        rows[2] = '{16'd1234, 16'd5002, 32'hc0a8_0103, 16'd13, 1, 1'b0};
        rows[3] = '{16'd1234, 16'd5003, 32'h0a00_0001, 16'd52, 6, 1'b0};
        rows[4] = '{16'd1234, 16'd5004, 32'h0a00_0002, 16'd48, 5, 1'b1};
        rows[5] = '{16'd1235, 16'd5005, 32'h0a00_0003, 16'd24, 2, 1'b1};
        rows[6] = '{16'd1234, 16'd5006, 32'hac10_0001, 16'd165, 20, 1'b1};
        rows[7] = '{16'd1234, 16'd5007, 32'hac10_0002, 16'd25, 3, 1'b1};
    endtask

    // cycle watchdog, limit follows the table length
    initial begin
        wait (cycle_limit > 0);
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        n_other++;
        $display("timeout after %0d cycles, %0d headers and %0d beats never came out",
                 cycles, exp_ip_q.size(), exp_data_q.size());
        print_counts();
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        int            total_beats;
        logic          match;
        payload_data_t data;
        payload_keep_t keep;
        logic          user;
        logic          last;

        rx_hdr_valid     = 1'b0;
        rx_hdr_src_ip    = '0;
        rx_hdr_src_port  = '0;
        rx_hdr_dest_port = '0;
        rx_hdr_length    = '0;
        rx_payload_data  = '0;
        rx_payload_keep  = '0;
        rx_payload_valid = 1'b0;
        rx_payload_last  = 1'b0;
        rx_payload_user  = 1'b0;
        tx_hdr_ready     = 1'b1;
        tx_payload_ready = 1'b1;
        lfsr        = 32'hb41bc855;
        bp_on       = 1'b0;
        out_first   = 1'b1;
        led_pending = 1'b0;
        led_expect  = '0;
        cycles      = 0;
        n_checks    = 0;
        n_mismatch  = 0;
        n_other     = 0;

        load_table();
        total_beats = 0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            total_beats += rows[r].beats;
        end
        cycle_limit = 8 * total_beats + 200;

        do begin
            next_cycle();
        end while (rst_seen);

        // idle outputs straight after reset
        check_bit("tx_hdr_valid", 1'b0, tx_hdr_valid);
        check_bit("tx_payload_valid", 1'b0, tx_payload_valid);
        check_bit("rx_payload_ready", 1'b0, rx_payload_ready);
        check_led("led", 8'h00, led);

        for (int r = 0; r < NUM_ROWS; r++) begin
            bp_on = rows[r].bp;
            match = (rows[r].dest_port == LOOPBACK_PORT);
            rx_hdr_valid     = 1'b1;
            rx_hdr_src_ip    = rows[r].src_ip;
            rx_hdr_src_port  = rows[r].src_port;
            rx_hdr_dest_port = rows[r].dest_port;
            rx_hdr_length    = rows[r].length;
            // reply swaps the ports and returns to the sender
            if (match) begin
                exp_ip_q.push_back(rows[r].src_ip);
                exp_sport_q.push_back(rows[r].dest_port);
                exp_dport_q.push_back(rows[r].src_port);
                exp_len_q.push_back(rows[r].length);
            end
            do begin
                next_cycle();
            end while (!hdr_fired);
            rx_hdr_valid = 1'b0;

            for (int b = 0; b < rows[r].beats; b++) begin
                data = draw_data();
                user = draw_bit();
                last = (b == rows[r].beats - 1);
                keep = last ? last_keep(rows[r].length) : 8'hff;
                rx_payload_valid = 1'b1;
                rx_payload_data  = data;
                rx_payload_keep  = keep;
                rx_payload_last  = last;
                rx_payload_user  = user;
                // dropped frames leave nothing behind
                if (match) begin
                    exp_data_q.push_back(data);
                    exp_keep_q.push_back(keep);
                    exp_last_q.push_back(last);
                    exp_user_q.push_back(user);
                end
                do begin
                    next_cycle();
                end while (!pay_fired);
            end
            rx_payload_valid = 1'b0;
            rx_payload_last  = 1'b0;
        end

        // drain, then watch for stray output
        while (exp_ip_q.size() != 0 || exp_data_q.size() != 0) begin
            next_cycle();
        end
        repeat (10) next_cycle();

        print_counts();
        if (n_mismatch == 0 && n_other == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f --top-module udp_loopback_tb -o udp_loopback_sim

output=$(./obj_dir/udp_loopback_sim)
echo "$output"

if grep -qx "NO ERRORS" <<< "$output"; then
    exit 0
fi
exit 1

// File: source/frame_byte_led.sv
// first payload byte display
`timescale 1ns/10ps

module frame_byte_led (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   payload_valid,
    input  logic                   payload_ready,
    input  logic                   payload_last,
    input  udp_pkg::payload_data_t payload_data,
    output udp_pkg::led_byte_t     led
);
    import udp_pkg::*;

    logic first_beat;
    logic xfer;

    assign xfer = payload_valid && payload_ready;

    // first_beat marks the start of the next outgoing frame
    always_ff @(posedge clk) begin
        if (rst) begin
            first_beat <= 1'b1;
            led        <= '0;
        end else if (xfer) begin
            first_beat <= payload_last;
            // low byte of the opening beat only
            if (first_beat) begin
                led <= led_byte_t'(payload_data[7:0]);
            end
        end
    end

endmodule

// File: source/udp_loopback_top.sv
// udp loopback top level
`timescale 1ns/10ps

module udp_loopback_top #(
    parameter udp_pkg::udp_port_t LOOPBACK_PORT   = 16'd1234,
    parameter int                 FIFO_ADDR_WIDTH = 4
) (
    input  logic                   clk,
    input  logic                   rst,

    // udp header in
    input  logic                   rx_hdr_valid,
    output logic                   rx_hdr_ready,
    input  udp_pkg::ip_addr_t      rx_hdr_src_ip,
    input  udp_pkg::udp_port_t     rx_hdr_src_port,
    input  udp_pkg::udp_port_t     rx_hdr_dest_port,
    input  udp_pkg::udp_len_t      rx_hdr_length,

    // payload in
    input  udp_pkg::payload_data_t rx_payload_data,
    input  udp_pkg::payload_keep_t rx_payload_keep,
    input  logic                   rx_payload_valid,
    output logic                   rx_payload_ready,
    input  logic                   rx_payload_last,
    input  logic                   rx_payload_user,

    // reply header out
    output logic                   tx_hdr_valid,
    input  logic                   tx_hdr_ready,
    output udp_pkg::ip_addr_t      tx_hdr_dest_ip,
    output udp_pkg::udp_port_t     tx_hdr_src_port,
    output udp_pkg::udp_port_t     tx_hdr_dest_port,
    output udp_pkg::udp_len_t      tx_hdr_length,

    // payload out
    output udp_pkg::payload_data_t tx_payload_data,
    output udp_pkg::payload_keep_t tx_payload_keep,
    output logic                   tx_payload_valid,
    input  logic                   tx_payload_ready,
    output logic                   tx_payload_last,
    output logic                   tx_payload_user,

    output udp_pkg::led_byte_t     led
);
    import udp_pkg::*;

    // filter to fifo
    payload_data_t fifo_in_data;
    payload_keep_t fifo_in_keep;
    logic          fifo_in_valid;
    logic          fifo_in_ready;
    logic          fifo_in_last;
    logic          fifo_in_user;

    udp_port_filter #(
        .LOOPBACK_PORT(LOOPBACK_PORT)
    ) filter0 (
        .clk(clk),
        .rst(rst),
        .rx_hdr_valid(rx_hdr_valid),
        .rx_hdr_ready(rx_hdr_ready),
        .rx_hdr_src_ip(rx_hdr_src_ip),
        .rx_hdr_src_port(rx_hdr_src_port),
        .rx_hdr_dest_port(rx_hdr_dest_port),
        .rx_hdr_length(rx_hdr_length),
        .rx_payload_data(rx_payload_data),
        .rx_payload_keep(rx_payload_keep),
        .rx_payload_valid(rx_payload_valid),
        .rx_payload_ready(rx_payload_ready),
        .rx_payload_last(rx_payload_last),
        .rx_payload_user(rx_payload_user),
        .tx_hdr_valid(tx_hdr_valid),
        .tx_hdr_ready(tx_hdr_ready),
        .tx_hdr_dest_ip(tx_hdr_dest_ip),
        .tx_hdr_src_port(tx_hdr_src_port),
        .tx_hdr_dest_port(tx_hdr_dest_port),
        .tx_hdr_length(tx_hdr_length),
        .fifo_in_data(fifo_in_data),
        .fifo_in_keep(fifo_in_keep),
        .fifo_in_valid(fifo_in_valid),
        .fifo_in_ready(fifo_in_ready),
        .fifo_in_last(fifo_in_last),
        .fifo_in_user(fifo_in_user)
    );

    udp_payload_fifo #(
        .FIFO_ADDR_WIDTH(FIFO_ADDR_WIDTH)
    ) fifo0 (
        .clk(clk),
        .rst(rst),
        .fifo_in_data(fifo_in_data),
        .fifo_in_keep(fifo_in_keep),
        .fifo_in_valid(fifo_in_valid),
        .fifo_in_ready(fifo_in_ready),
        .fifo_in_last(fifo_in_last),
        .fifo_in_user(fifo_in_user),
        .tx_payload_data(tx_payload_data),
        .tx_payload_keep(tx_payload_keep),
        .tx_payload_valid(tx_payload_valid),
        .tx_payload_ready(tx_payload_ready),
        .tx_payload_last(tx_payload_last),
        .tx_payload_user(tx_payload_user)
    );

    // watches the outgoing payload only
    frame_byte_led led0 (
        .clk(clk),
        .rst(rst),
        .payload_valid(tx_payload_valid),
        .payload_ready(tx_payload_ready),
        .payload_last(tx_payload_last),
        .payload_data(tx_payload_data),
        .led(led)
    );

endmodule

// File: source/udp_payload_fifo.sv
// udp payload fifo
`timescale 1ns/10ps

module udp_payload_fifo #(
    parameter int FIFO_ADDR_WIDTH = 4
) (
    input  logic                   clk,
    input  logic                   rst,

    // write side from the filter
    input  udp_pkg::payload_data_t fifo_in_data,
    input  udp_pkg::payload_keep_t fifo_in_keep,
    input  logic                   fifo_in_valid,
    output logic                   fifo_in_ready,
    input  logic                   fifo_in_last,
    input  logic                   fifo_in_user,

    // registered read side
    output udp_pkg::payload_data_t tx_payload_data,
    output udp_pkg::payload_keep_t tx_payload_keep,
    output logic                   tx_payload_valid,
    input  logic                   tx_payload_ready,
    output logic                   tx_payload_last,
    output logic                   tx_payload_user
);
    import udp_pkg::*;

    localparam int DEPTH = 2 ** FIFO_ADDR_WIDTH;

    // entry storage
    payload_data_t mem_data [DEPTH];
    payload_keep_t mem_keep [DEPTH];
    logic          mem_last [DEPTH];
    logic          mem_user [DEPTH];

    // pointers carry one extra wrap bit
    logic [FIFO_ADDR_WIDTH:0] wr_ptr;
    logic [FIFO_ADDR_WIDTH:0] rd_ptr;

    logic full;
    logic empty;
    logic wr_en;
    logic rd_en;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[FIFO_ADDR_WIDTH] != rd_ptr[FIFO_ADDR_WIDTH]) &&
                   (wr_ptr[FIFO_ADDR_WIDTH-1:0] == rd_ptr[FIFO_ADDR_WIDTH-1:0]);

    assign fifo_in_ready = !full;
    assign wr_en         = fifo_in_valid && !full;
    // refill output stage when it is free or being taken
    assign rd_en         = !empty && (!tx_payload_valid || tx_payload_ready);

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem_data[wr_ptr[FIFO_ADDR_WIDTH-1:0]] <= fifo_in_data;
            mem_keep[wr_ptr[FIFO_ADDR_WIDTH-1:0]] <= fifo_in_keep;
            mem_last[wr_ptr[FIFO_ADDR_WIDTH-1:0]] <= fifo_in_last;
            mem_user[wr_ptr[FIFO_ADDR_WIDTH-1:0]] <= fifo_in_user;
        end
        if (rd_en) begin
            tx_payload_data <= mem_data[rd_ptr[FIFO_ADDR_WIDTH-1:0]];
            tx_payload_keep <= mem_keep[rd_ptr[FIFO_ADDR_WIDTH-1:0]];
            tx_payload_last <= mem_last[rd_ptr[FIFO_ADDR_WIDTH-1:0]];
            tx_payload_user <= mem_user[rd_ptr[FIFO_ADDR_WIDTH-1:0]];
        end
    end

    // pointers and output valid
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr           <= '0;
            rd_ptr           <= '0;
            tx_payload_valid <= 1'b0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr           <= rd_ptr + 1'b1;
                tx_payload_valid <= 1'b1;
            end else if (tx_payload_ready) begin
                tx_payload_valid <= 1'b0;
            end
        end
    end

endmodule

// File: source/udp_pkg.sv
// udp loopback shared types
package udp_pkg;

    // payload beat geometry
    localparam int DATA_W = 64;
    localparam int KEEP_W = DATA_W / 8;

    // one payload beat and its byte enables
    typedef logic [DATA_W-1:0] payload_data_t;
    typedef logic [KEEP_W-1:0] payload_keep_t;

    // udp header fields carried on the header channels
    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] udp_port_t;
    typedef logic [15:0] udp_len_t;

    // led display byte
    typedef logic [7:0] led_byte_t;

    // per-frame decision held by the port filter
    typedef enum logic [1:0] {
        // waiting for the next header
        FILT_IDLE,
        // matched frame, payload goes to the fifo
        FILT_PASS,
        // foreign port, payload is sunk
        FILT_DROP
    } filter_state_t;

endpackage

// File: source/udp_port_filter.sv
// udp destination port filter
`timescale 1ns/10ps

module udp_port_filter #(
    parameter udp_pkg::udp_port_t LOOPBACK_PORT = 16'd1234
) (
    input  logic                   clk,
    input  logic                   rst,

    // incoming udp header
    input  logic                   rx_hdr_valid,
    output logic                   rx_hdr_ready,
    input  udp_pkg::ip_addr_t      rx_hdr_src_ip,
    input  udp_pkg::udp_port_t     rx_hdr_src_port,
    input  udp_pkg::udp_port_t     rx_hdr_dest_port,
    input  udp_pkg::udp_len_t      rx_hdr_length,

    // incoming payload
    input  udp_pkg::payload_data_t rx_payload_data,
    input  udp_pkg::payload_keep_t rx_payload_keep,
    input  logic                   rx_payload_valid,
    output logic                   rx_payload_ready,
    input  logic                   rx_payload_last,
    input  logic                   rx_payload_user,

    // reply header
    output logic                   tx_hdr_valid,
    input  logic                   tx_hdr_ready,
    output udp_pkg::ip_addr_t      tx_hdr_dest_ip,
    output udp_pkg::udp_port_t     tx_hdr_src_port,
    output udp_pkg::udp_port_t     tx_hdr_dest_port,
    output udp_pkg::udp_len_t      tx_hdr_length,

    // matched payload towards the fifo
    output udp_pkg::payload_data_t fifo_in_data,
    output udp_pkg::payload_keep_t fifo_in_keep,
    output logic                   fifo_in_valid,
    input  logic                   fifo_in_ready,
    output logic                   fifo_in_last,
    output logic                   fifo_in_user
);
    import udp_pkg::*;

    filter_state_t state;

    logic port_match;
    logic hdr_accept;
    logic last_accept;

    // decision for the header on the input right now
    assign port_match = (rx_hdr_dest_port == LOOPBACK_PORT);

    // header taken only between frames, and only with room in the reply slot
    assign rx_hdr_ready = (state == FILT_IDLE) && (!tx_hdr_valid || tx_hdr_ready);
    assign hdr_accept   = rx_hdr_valid && rx_hdr_ready;

    // payload gating, nothing moves while idle
    assign fifo_in_valid    = rx_payload_valid && (state == FILT_PASS);
    assign rx_payload_ready = (state == FILT_PASS) ? fifo_in_ready : (state == FILT_DROP);
    assign fifo_in_data     = rx_payload_data;
    assign fifo_in_keep     = rx_payload_keep;
    assign fifo_in_last     = rx_payload_last;
    assign fifo_in_user     = rx_payload_user;

    // end of frame on the input side
    assign last_accept = rx_payload_valid && rx_payload_ready && rx_payload_last;

    // frame decision, held until the last beat
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= FILT_IDLE;
        end else begin
            case (state)
                FILT_IDLE: begin
                    if (hdr_accept) begin
                        state <= port_match ? FILT_PASS : FILT_DROP;
                    end
                end
                FILT_PASS, FILT_DROP: begin
                    if (last_accept) begin
                        state <= FILT_IDLE;
                    end
                end
                default: state <= FILT_IDLE;
            endcase
        end
    end

    // one-entry reply header slot
    always_ff @(posedge clk) begin
        if (rst) begin
            tx_hdr_valid <= 1'b0;
        end else if (hdr_accept && port_match) begin
            tx_hdr_valid <= 1'b1;
        end else if (tx_hdr_ready) begin
            tx_hdr_valid <= 1'b0;
        end
    end

    // swapped fields, sender becomes destination
    always_ff @(posedge clk) begin
        if (hdr_accept && port_match) begin
            tx_hdr_dest_ip   <= rx_hdr_src_ip;
            tx_hdr_src_port  <= rx_hdr_dest_port;
            tx_hdr_dest_port <= rx_hdr_src_port;
            tx_hdr_length    <= rx_hdr_length;
        end
    end

endmodule

// File: verilog.f
source/udp_pkg.sv
source/udp_port_filter.sv
source/udp_payload_fifo.sv
source/frame_byte_led.sv
source/udp_loopback_top.sv
bench/clock_gen.sv
bench/udp_loopback_assert.sv
bench/udp_loopback_tb.sv
